// File: hw/branch_decoder.sv
// Jump, branch and xRET classification with branch target adder.
module branch_decoder (
    input  logic [rv_decode_pkg::ilen-1:0] insn,
    input  logic [rv_decode_pkg::xlen-1:1] pc,
    input  logic [rv_decode_pkg::xlen-1:0] rs1_val,

    output logic                           is_xret,
    output logic                           is_branch,
    output logic                           is_jump,
    output logic [rv_decode_pkg::xlen-1:1] target,
    output logic                           use_rs1
);
    import rv_decode_pkg::*;

    opcode_t         opcode;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] base;
    logic [xlen-1:0] offset;
    logic [xlen-1:0] sum;

    assign opcode = opcode_t'(insn[opcode_hi:opcode_lo]);

    // Sign-extended immediates.
    assign imm_j = {{(xlen-20){insn[31]}}, insn[rs1_hi:funct3_lo], insn[rs2_lo],
                    insn[30:21], 1'b0};
    assign imm_i = {{(xlen-12){insn[31]}}, insn[31:rs2_lo]};
    assign imm_b = {{(xlen-12){insn[31]}}, insn[rd_lo], insn[funct7_hi-1:funct7_lo],
                    insn[rd_hi:rd_lo+1], 1'b0};

    always_comb begin
        is_xret   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        use_rs1   = 1'b0;
        base      = {pc, 1'b0};
        offset    = '0;
        case (opcode)
            JAL: begin
                is_jump = 1'b1;
                offset  = imm_j;
            end
            JALR: begin
                is_jump = 1'b1;
                use_rs1 = 1'b1;
                base    = rs1_val;
                offset  = imm_i;
            end
            BRANCH: begin
                is_branch = 1'b1;
                offset    = imm_b;
            end
            SYSTEM: begin
                // MRET and SRET share bits 21 and 28.
                is_xret = insn[funct3_hi:funct3_lo] == 3'b000 && insn[21] && insn[28];
            end
            default: begin
                is_xret = 1'b0;
            end
        endcase
    end

    // Bit 0 of the sum is dropped, as JALR requires.
    assign sum    = base + offset;
    assign target = sum[xlen-1:1];

endmodule

// File: hw/id_regfile.sv
// General-purpose register file with x0 tied to zero, one write and two read ports.
module id_regfile (
    input  logic                                clk,
    input  logic                                rst,

    // Write-back port.
    input  logic                                we,
    input  logic [rv_decode_pkg::reg_idx_w-1:0] rd,
    input  logic [rv_decode_pkg::xlen-1:0]      wdata,

    // Read ports.
    input  logic [rv_decode_pkg::reg_idx_w-1:0] rs1,
    input  logic [rv_decode_pkg::reg_idx_w-1:0] rs2,
    output logic [rv_decode_pkg::xlen-1:0]      q1,
    output logic [rv_decode_pkg::xlen-1:0]      q2
);
    import rv_decode_pkg::*;

    // Storage for x1 to x31.
    logic [xlen-1:0] storage [1:31];

    // Combinational reads, x0 is always zero.
    assign q1 = (rs1 == '0) ? '0 : storage[rs1];
    assign q2 = (rs2 == '0) ? '0 : storage[rs2];

    // Writes land on the clock edge, so reads see the old value this cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                storage[i] <= '0;
            end
        end else if (we && rd != '0) begin
            storage[rd] <= wdata;
        end
    end

endmodule

// File: hw/id_stage.sv
// Instruction decode stage: IF/ID barrier register, decoders, trap priority and outputs.
module id_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clear,
    input  logic                                stall,

    // From fetch.
    input  logic                                d_valid,
    input  logic [rv_decode_pkg::xlen-1:1]      d_pc,
    input  logic [rv_decode_pkg::ilen-1:0]      d_insn,
    input  logic                                d_trap,
    input  rv_decode_pkg::cause_t               d_cause,

    // From write-back.
    input  logic                                wb_we,
    input  logic [rv_decode_pkg::reg_idx_w-1:0] wb_rd,
    input  logic [rv_decode_pkg::xlen-1:0]      wb_wdata,

    // To execute.
    output logic                                q_valid,
    output logic [rv_decode_pkg::xlen-1:1]      q_pc,
    output logic [rv_decode_pkg::ilen-1:0]      q_insn,
    output logic                                q_use_rd,
    output logic [rv_decode_pkg::xlen-1:0]      q_rs1_val,
    output logic [rv_decode_pkg::xlen-1:0]      q_rs2_val,
    output logic                                q_trap,
    output rv_decode_pkg::cause_t               q_cause,

    // Control flow flags.
    output logic                                is_fencei,
    output logic                                is_xret,
    output logic                                is_sret,
    output logic                                is_jump,
    output logic                                is_branch,
    output logic                                branch_predict,
    output logic [rv_decode_pkg::xlen-1:1]      branch_target,
    output logic                                use_rs1_bt
);
    import rv_decode_pkg::*;

    logic            r_valid;
    logic [xlen-1:1] r_pc;
    logic [ilen-1:0] r_insn;
    logic            r_trap;
    cause_t          r_cause;

    logic            insn_valid;
    logic            is_system_priv;
    logic            is_ecall;
    logic            is_ebreak;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    // IF/ID barrier, held while stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_trap  <= 1'b0;
            r_insn  <= '0;
        end else if (!stall) begin
            r_valid <= d_valid;
            r_trap  <= d_trap;
            r_insn  <= d_insn;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            r_pc    <= d_pc;
            r_cause <= d_cause;
        end
    end

    id_regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .we    (wb_we),
        .rd    (wb_rd),
        .wdata (wb_wdata),
        .rs1   (r_insn[rs1_hi:rs1_lo]),
        .rs2   (r_insn[rs2_hi:rs2_lo]),
        .q1    (rs1_val),
        .q2    (rs2_val)
    );

    insn_validator u_validator (
        .insn  (r_insn),
        .valid (insn_valid)
    );

    reg_use_decoder u_reg_use (
        .insn   (r_insn),
        .use_rd (q_use_rd)
    );

    branch_decoder u_branch (
        .insn      (r_insn),
        .pc        (r_pc),
        .rs1_val   (rs1_val),
        .is_xret   (is_xret),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .target    (branch_target),
        .use_rs1   (use_rs1_bt)
    );

    // ECALL and EBREAK differ only in bit 20.
    assign is_system_priv = r_insn[opcode_hi:opcode_lo] == SYSTEM
                         && r_insn[funct3_hi:funct3_lo] == 3'b000;
    assign is_ecall  = is_system_priv && r_insn[31:20] == 12'h000;
    assign is_ebreak = is_system_priv && r_insn[31:20] == 12'h001;

    assign is_fencei = r_valid && r_insn[1:0] == 2'b11
                    && r_insn[opcode_hi:opcode_lo] == MISC_MEM
                    && r_insn[funct3_hi:funct3_lo] == 3'b001;

    // Static prediction from the immediate sign.
    assign branch_predict = r_insn[31];
    assign is_sret        = !r_insn[29];

    assign q_pc      = r_pc;
    assign q_insn    = r_insn;
    assign q_rs1_val = rs1_val;
    assign q_rs2_val = rs2_val;

    // Trap selection, fetch trap first.
    always_comb begin
        q_valid = 1'b0;
        q_trap  = !clear;
        q_cause = r_cause;
        if (r_trap) begin
            q_cause = r_cause;
        end else if (r_valid && !insn_valid) begin
            q_cause = CAUSE_ILLEGAL_INSN;
        end else if (r_valid && is_ecall) begin
            q_cause = CAUSE_M_ECALL;
        end else if (r_valid && is_ebreak) begin
            q_cause = CAUSE_EBREAK;
        end else begin
            q_valid = r_valid && !clear;
            q_trap  = 1'b0;
        end
    end

endmodule

// File: hw/insn_validator.sv
// Validity check for uncompressed RV32IM instruction encodings.
module insn_validator (
    input  logic [rv_decode_pkg::ilen-1:0] insn,
    output logic                           valid
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       valid_op_imm;
    logic       valid_op;
    logic       valid_system;

    assign opcode = opcode_t'(insn[opcode_hi:opcode_lo]);
    assign funct3 = insn[funct3_hi:funct3_lo];
    assign funct7 = insn[funct7_hi:funct7_lo];

    // Immediate ALU ops; only the shifts constrain the upper bits.
    always_comb begin
        if (funct3 == alu_sll) begin
            valid_op_imm = funct7 == 7'h00;
        end else if (funct3 == alu_srl) begin
            // SRLI or SRAI.
            valid_op_imm = funct7 == 7'h00 || funct7 == 7'h20;
        end else begin
            valid_op_imm = 1'b1;
        end
    end

    // Register ALU ops, M extension always present.
    always_comb begin
        if (funct7 == 7'h00 || funct7 == 7'h01) begin
            valid_op = 1'b1;
        end else if (funct7 == 7'h20) begin
            // SUB and SRA only.
            valid_op = funct3 == alu_add || funct3 == alu_srl;
        end else begin
            valid_op = 1'b0;
        end
    end

    // SYSTEM opcode.
    always_comb begin
        if (funct3 == 3'b000) begin
            // Privileged forms carry no rs1 or rd.
            casez (insn[31:20])
                12'b0000000_0000?: valid_system = 1'b1; // ECALL, EBREAK
                12'b00?1000_00010: valid_system = 1'b1; // MRET, SRET
                12'b0001000_00101: valid_system = 1'b1; // WFI
                default:           valid_system = 1'b0;
            endcase
            if (insn[rs1_hi:rs1_lo] != '0 || insn[rd_hi:rd_lo] != '0) begin
                valid_system = 1'b0;
            end
        end else begin
            // CSR access forms.
            valid_system = funct3 != 3'b100;
        end
    end

    // Per-opcode selection.
    always_comb begin
        valid = 1'b0;
        if (insn[1:0] == 2'b11) begin
            case (opcode)
                LOAD:     valid = insn[14] ? (insn[13:12] < 2'd2) : (insn[13:12] < 2'd3);
                MISC_MEM: valid = funct3 == 3'b000 || funct3 == 3'b001;
                OP_IMM:   valid = valid_op_imm;
                AUIPC:    valid = 1'b1;
                STORE:    valid = !insn[14] && (insn[13:12] < 2'd3);
                OP:       valid = valid_op;
                LUI:      valid = 1'b1;
                BRANCH:   valid = insn[14] || !insn[13];
                JALR:     valid = funct3 == 3'b000;
                JAL:      valid = 1'b1;
                SYSTEM:   valid = valid_system;
                default:  valid = 1'b0;
            endcase
        end
    end

endmodule

// File: hw/reg_use_decoder.sv
// Destination register use decoder.
module reg_use_decoder (
    input  logic [rv_decode_pkg::ilen-1:0] insn,
    output logic                           use_rd
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_t'(insn[opcode_hi:opcode_lo]);
    assign funct3 = insn[funct3_hi:funct3_lo];

    always_comb begin
        case (opcode)
            LOAD,
            OP_IMM,
            AUIPC,
            OP,
            LUI,
            JALR,
            JAL: begin
                use_rd = 1'b1;
            end
            SYSTEM: begin
                // CSR forms write the old CSR value to rd.
                use_rd = funct3 != 3'b000;
            end
            default: begin
                // Stores, branches and fences.
                use_rd = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/rv_decode_pkg.sv
// Decode package: widths, opcode and trap-cause enums, ALU funct3 codes, field positions.
package rv_decode_pkg;

    // Data and instruction widths.
    localparam int xlen      = 32;
    localparam int ilen      = 32;
    localparam int reg_idx_w = 5;

    // Major opcodes, taken from insn[6:2].
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_t;

    // Exception causes raised by this stage.
    // Fetch may pass through other codes.
    typedef enum logic [3:0] {
        CAUSE_ILLEGAL_INSN = 4'd2,
        CAUSE_EBREAK       = 4'd3,
        CAUSE_M_ECALL      = 4'd11
    } cause_t;

    // ALU funct3 values with extra funct7 encodings.
    localparam logic [2:0] alu_add = 3'b000;
    localparam logic [2:0] alu_sll = 3'b001;
    localparam logic [2:0] alu_srl = 3'b101;

    // Instruction field positions.
    localparam int opcode_lo = 2;
    localparam int opcode_hi = 6;
    localparam int rd_lo     = 7;
    localparam int rd_hi     = 11;
    localparam int funct3_lo = 12;
    localparam int funct3_hi = 14;
    localparam int rs1_lo    = 15;
    localparam int rs1_hi    = 19;
    localparam int rs2_lo    = 20;
    localparam int rs2_hi    = 24;
    localparam int funct7_lo = 25;
    localparam int funct7_hi = 31;

endpackage

// File: id_stage.f
hw/rv_decode_pkg.sv
hw/id_regfile.sv
hw/insn_validator.sv
hw/reg_use_decoder.sv
hw/branch_decoder.sv
hw/id_stage.sv
verification/id_checker.sv
verification/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary -f id_stage.f --top-module id_stage_tb -Mdir obj_dir -o id_stage_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/id_stage_sim > sim.log 2>&1
cat sim.log

grep -qx '>>> PASS' sim.log && exit 0 || exit 1

// File: verification/id_checker.sv
// Result checker for the decode stage: compares DUT outputs with expected values per test.
module id_checker (
    input  logic         clk,
    input  logic         check_en,
    input  logic [127:0] test_name,

    // Expected values for the current test.
    input  logic [8:0]   exp_flags,
    input  logic [3:0]   exp_cause,
    input  logic [31:0]  exp_rs1,
    input  logic [31:0]  exp_rs2,
    input  logic [31:0]  exp_target,
    input  logic [31:0]  exp_insn,
    input  logic [31:0]  exp_pc,
    input  logic         exp_predict,

    // Observed DUT outputs.
    input  logic         q_valid,
    input  logic         q_trap,
    input  logic [3:0]   q_cause,
    input  logic         q_use_rd,
    input  logic [31:0]  q_rs1_val,
    input  logic [31:0]  q_rs2_val,
    input  logic [31:0]  q_insn,
    input  logic [31:1]  q_pc,
    input  logic         is_jump,
    input  logic         is_branch,
    input  logic         use_rs1_bt,
    input  logic         is_fencei,
    input  logic         is_xret,
    input  logic         is_sret,
    input  logic         branch_predict,
    input  logic [31:1]  branch_target,

    output int           pass_count,
    output int           fail_count,
    output int           checks_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int passes = 0;
    int fails  = 0;
    int done   = 0;

    assign pass_count  = passes;
    assign fail_count  = fails;
    assign checks_done = done;

    // Sampled mid-cycle, away from the edge where inputs and registers move.
    always @(negedge clk) begin
        logic [8:0]  act_flags;
        logic [31:0] act_target;
        if (check_en) begin
            act_flags  = {q_valid, q_trap, q_use_rd, is_jump, is_branch, use_rs1_bt,
                          is_fencei, is_xret, is_sret};
            act_target = {branch_target, 1'b0};
            if (act_flags == exp_flags && q_cause == exp_cause && q_rs1_val == exp_rs1
                && q_rs2_val == exp_rs2 && act_target[31:1] == exp_target[31:1]
                && q_insn == exp_insn && q_pc == exp_pc[31:1]
                && branch_predict == exp_predict) begin
                passes++;
                $display("ok %0s", test_name);
            end else begin
                fails++;
                $write("mismatch %0s expected flags=%b cause=%h rs1=%h rs2=%h",
                       test_name, exp_flags, exp_cause, exp_rs1, exp_rs2);
                $write(" tgt=%h pc=%h bp=%b insn=%h", {exp_target[31:1], 1'b0},
                       {exp_pc[31:1], 1'b0}, exp_predict, exp_insn);
                $write(" actual flags=%b cause=%h rs1=%h rs2=%h",
                       act_flags, q_cause, q_rs1_val, q_rs2_val);
                $display(" tgt=%h pc=%h bp=%b insn=%h",
                         act_target, {q_pc, 1'b0}, branch_predict, q_insn);
            end
            done++;
        end
    end

endmodule

// File: verification/id_stage_input.txt
# name dv pc insn trap cause we rd wdata stall clear | flags(v t rd j b rs1 fi xr sr)
# exp_cause exp_rs1 exp_rs2 exp_target exp_insn; all numbers hex except flags (binary)
reset_state 0 000 00628033 0 0 0 00 00000000 0 0 001000001 0 00000000 00000000 00000000 00628033
wb_x5       1 100 00628033 0 0 1 05 12345678 0 0 101000001 0 12345678 00000000 00000100 00628033
wb_x6       1 104 00628033 0 0 1 06 deadbeef 0 0 101000001 0 12345678 deadbeef 00000104 00628033
wb_x0       1 108 00600033 0 0 1 00 ffffffff 0 0 101000001 0 00000000 deadbeef 00000108 00600033
jal_fwd     1 200 010000ef 0 0 0 00 00000000 0 0 101100001 0 00000000 00000000 00000210 010000ef
jal_back    1 300 ff9ff06f 0 0 0 00 00000000 0 0 101100000 0 00000000 00000000 000002f8 ff9ff06f
jalr        1 400 008280e7 0 0 0 00 00000000 0 0 101101001 0 12345678 00000000 12345680 008280e7
jalr_neg    1 404 ffd30067 0 0 0 00 00000000 0 0 101101000 0 deadbeef 00000000 deadbeec ffd30067
beq_fwd     1 500 02628063 0 0 0 00 00000000 0 0 100010001 0 12345678 deadbeef 00000520 02628063
bne_back    1 600 fe6298e3 0 0 0 00 00000000 0 0 100010000 0 12345678 deadbeef 000005f0 fe6298e3
fetch_trap  1 700 00000000 1 1 0 00 00000000 0 0 011000001 1 00000000 00000000 00000700 00000000
illegal     1 800 ffffffff 0 0 0 00 00000000 0 0 010000000 2 00000000 00000000 00000800 ffffffff
ecall       1 900 00000073 0 0 0 00 00000000 0 0 010000001 b 00000000 00000000 00000900 00000073
ebreak      1 904 00100073 0 0 0 00 00000000 0 0 010000001 3 00000000 00000000 00000904 00100073
ecall_clear 1 908 00000073 0 0 0 00 00000000 0 1 000000001 b 00000000 00000000 00000908 00000073
add_clear   1 90c 00628033 0 0 0 00 00000000 0 1 001000001 0 12345678 deadbeef 0000090c 00628033
mret        1 a00 30200073 0 0 0 00 00000000 0 0 100000010 0 00000000 00000000 00000a00 30200073
stall_hold  1 b00 10200073 0 0 0 00 00000000 1 0 100000010 0 00000000 00000000 00000a00 30200073
sret        1 b00 10200073 0 0 0 00 00000000 0 0 100000011 0 00000000 00000000 00000b00 10200073
fencei      1 c00 0000100f 0 0 0 00 00000000 0 0 100000101 0 00000000 00000000 00000c00 0000100f
fence       1 c04 0ff0000f 0 0 0 00 00000000 0 0 100000001 0 00000000 00000000 00000c04 0ff0000f
csrrw       1 c08 300290f3 0 0 0 00 00000000 0 0 101000000 0 12345678 00000000 00000c08 300290f3
csr_f3_4    1 c0c 3002c0f3 0 0 0 00 00000000 0 0 011000000 2 12345678 00000000 00000c0c 3002c0f3
lw          1 d00 00432383 0 0 0 00 00000000 0 0 101000001 0 deadbeef 00000000 00000d00 00432383
sw          1 d04 00532423 0 0 0 00 00000000 0 0 100000001 0 deadbeef 12345678 00000d04 00532423
mul         1 d08 026280b3 0 0 0 00 00000000 0 0 101000001 0 12345678 deadbeef 00000d08 026280b3
bad_f7      1 d0c 406290b3 0 0 0 00 00000000 0 0 011000001 2 12345678 deadbeef 00000d0c 406290b3
lui         1 e00 123451b7 0 0 0 00 00000000 0 0 101000001 0 00000000 00000000 00000e00 123451b7
br_f3_2     1 e04 0262a063 0 0 0 00 00000000 0 0 010010001 2 12345678 deadbeef 00000e24 0262a063
wfi         1 e08 10500073 0 0 0 00 00000000 0 0 100000001 0 00000000 12345678 00000e08 10500073

// File: verification/id_stage_tb.sv
// Testbench top for the decode stage: clock, reset, file-driven stimulus and timeout.
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    localparam int max_tests    = 64;
    localparam int reset_cycles = 16;

    logic        clk;
    logic        rst;
    logic        clear;
    logic        stall;
    logic        d_valid;
    logic [31:1] d_pc;
    logic [31:0] d_insn;
    logic        d_trap;
    cause_t      d_cause;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_wdata;

    logic        q_valid;
    logic [31:1] q_pc;
    logic [31:0] q_insn;
    logic        q_use_rd;
    logic [31:0] q_rs1_val;
    logic [31:0] q_rs2_val;
    logic        q_trap;
    cause_t      q_cause;
    logic        is_fencei;
    logic        is_xret;
    logic        is_sret;
    logic        is_jump;
    logic        is_branch;
    logic        branch_predict;
    logic [31:1] branch_target;
    logic        use_rs1_bt;

    // Test table.
    logic [127:0] t_name   [max_tests];
    logic [4:0]   t_ctrl   [max_tests];
    logic [31:0]  t_pc     [max_tests];
    logic [31:0]  t_insn   [max_tests];
    logic [3:0]   t_cause  [max_tests];
    logic [4:0]   t_rd     [max_tests];
    logic [31:0]  t_wdata  [max_tests];
    logic [8:0]   e_flags  [max_tests];
    logic [3:0]   e_cause  [max_tests];
    logic [31:0]  e_rs1    [max_tests];
    logic [31:0]  e_rs2    [max_tests];
    logic [31:0]  e_target [max_tests];
    logic [31:0]  e_insn   [max_tests];

    logic         check_en;
    logic [127:0] chk_name;
    logic [8:0]   chk_flags;
    logic [3:0]   chk_cause;
    logic [31:0]  chk_rs1;
    logic [31:0]  chk_rs2;
    logic [31:0]  chk_target;
    logic [31:0]  chk_insn;
    logic [31:0]  chk_pc;
    logic         chk_predict;

    int num_tests = 0;
    int load_errors = 0;
    int timeout_limit = 64;
    int cycles = 0;
    int pass_count;
    int fail_count;
    int checks_done;

    id_stage u_id_stage (.*);

    id_checker u_checker (
        .clk (clk), .check_en (check_en), .test_name (chk_name),
        .exp_flags (chk_flags), .exp_cause (chk_cause), .exp_rs1 (chk_rs1),
        .exp_rs2 (chk_rs2), .exp_target (chk_target), .exp_insn (chk_insn),
        .exp_pc (chk_pc), .exp_predict (chk_predict),
        .q_valid (q_valid), .q_trap (q_trap), .q_cause (q_cause), .q_use_rd (q_use_rd),
        .q_rs1_val (q_rs1_val), .q_rs2_val (q_rs2_val), .q_insn (q_insn), .q_pc (q_pc),
        .is_jump (is_jump), .is_branch (is_branch), .use_rs1_bt (use_rs1_bt),
        .is_fencei (is_fencei), .is_xret (is_xret), .is_sret (is_sret),
        .branch_predict (branch_predict),
        .branch_target (branch_target), .pass_count (pass_count),
        .fail_count (fail_count), .checks_done (checks_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Comment lines start with '#'.
    task automatic load_tests();
        int           fd;
        int           n;
        string        line;
        logic [127:0] name;
        logic [31:0]  v [16];
        fd = $fopen("verification/id_stage_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the test input file");
            load_errors++;
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %b %h %h %h %h %h",
                                name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                    if (n == 17) begin
                        t_name[num_tests]   = name;
                        t_ctrl[num_tests]   = {v[0][0], v[3][0], v[5][0], v[8][0], v[9][0]};
                        t_pc[num_tests]     = v[1];
                        t_insn[num_tests]   = v[2];
                        t_cause[num_tests]  = v[4][3:0];
                        t_rd[num_tests]     = v[6][4:0];
                        t_wdata[num_tests]  = v[7];
                        e_flags[num_tests]  = v[10][8:0];
                        e_cause[num_tests]  = v[11][3:0];
                        e_rs1[num_tests]    = v[12];
                        e_rs2[num_tests]    = v[13];
                        e_target[num_tests] = v[14];
                        e_insn[num_tests]   = v[15];
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_stimulus(input int i);
        {d_valid, d_trap, wb_we, stall, clear} = t_ctrl[i];
        d_pc     = t_pc[i][31:1];
        d_insn   = t_insn[i];
        d_cause  = cause_t'(t_cause[i]);
        wb_rd    = t_rd[i];
        wb_wdata = t_wdata[i];
    endtask

    task automatic arm_check(input int i);
        chk_name    = t_name[i];
        chk_flags   = e_flags[i];
        chk_cause   = e_cause[i];
        chk_rs1     = e_rs1[i];
        chk_rs2     = e_rs2[i];
        chk_target  = e_target[i];
        chk_insn    = e_insn[i];
        // Static prediction is the sign bit of the held instruction.
        chk_predict = e_insn[i][31];
        // A stalled test still shows the pc of the last capture.
        if (!t_ctrl[i][1]) begin
            chk_pc = t_pc[i];
        end
        check_en    = 1'b1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(21519));
        {rst, clear, stall, d_valid, d_trap, wb_we, check_en} = 7'b1000000;
        d_pc = '0;
        d_insn = '0;
        d_cause = cause_t'(4'd0);
        wb_rd = '0;
        wb_wdata = '0;
        {chk_name, chk_flags, chk_cause} = '0;
        {chk_rs1, chk_rs2, chk_target, chk_insn} = '0;
        chk_pc = '0;
        chk_predict = 1'b0;
        load_tests();
        timeout_limit = num_tests * 4 + 64;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            @(posedge clk);
            #1 apply_stimulus(i);
            @(posedge clk);
            #1 arm_check(i);
            wait (checks_done == i + 1);
            check_en = 1'b0;
        end
        @(posedge clk);
        $display("tests %0d passed %0d failed %0d", num_tests, pass_count, fail_count);
        if (fail_count == 0 && load_errors == 0 && num_tests > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
